//--- bench/cam_ctl_patterns.txt
# columns in hex: wr adr data | rd adr expected | txchk byte | rxsend byte
# rnd takes a decimal count of random bytes, each received and transmitted
rd 0001 00000000
rd 0002 00000035
rd 0040 00000000
rd 0043 00000000
rd 0080 00000000
rd 03c0 00000000
wr 0040 0000fff5
rd 0040 00000005
wr 0041 00000001
rd 0041 00000001
wr 0042 000000a5
rd 0042 000000a5
wr 0043 0000ff3c
rd 0043 0000003c
wr 0002 00000003
rd 0002 00000003
txchk 5a
rxsend c3
rd 0000 000000c3
rd 0001 00000000
rxsend 11
rxsend 22
rd 0001 00000006
rd 0000 00000022
rd 0001 00000000
rnd 6

//--- bench/tb_cam_ctl.sv
`include "cam_ctl_params.svh"

module tb_cam_ctl;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_LIMIT  = 8;
    localparam int POLL_LIMIT = 200;
    localparam logic [`WB_ADR_WIDTH-1:0] UART_DATA   = 16'h0000;
    localparam logic [`WB_ADR_WIDTH-1:0] UART_STATUS = 16'h0001;

    logic                      clk;
    logic                      reset;
    logic [`WB_ADR_WIDTH-1:0]  wb_adr_i;
    logic [`WB_DAT_WIDTH-1:0]  wb_dat_i;
    logic [`WB_SEL_WIDTH-1:0]  wb_sel_i;
    logic                      wb_we_i;
    logic                      wb_stb_i;
    logic [`WB_DAT_WIDTH-1:0]  wb_dat_o;
    logic                      wb_ack_o;
    logic                      uart_rx_i;
    logic                      uart_tx_o;
    logic                      csi_rstn_o;
    logic [3:0]                led_n_o;
    logic [7:0]                pmod1_o;
    logic [7:0]                pmod2_o;

    // reference model of the register side
    logic [7:0]                gpio_m [4];
    logic [7:0]                div_m;
    logic                      rx_full_m;
    logic                      rx_ovr_m;
    logic [31:0]               lfsr_state;

    tb_clock u_tb_clock (.clk_o(clk), .reset_o(reset));

    cam_ctl_top u_cam_ctl_top (
        .clk(clk), .reset(reset),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
        .wb_we_i(wb_we_i), .wb_stb_i(wb_stb_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .uart_rx_i(uart_rx_i), .uart_tx_o(uart_tx_o), .csi_rstn_o(csi_rstn_o),
        .led_n_o(led_n_o), .pmod1_o(pmod1_o), .pmod2_o(pmod2_o)
    );

    // --------------------
    // error handling and compares
    task automatic abort_run;
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_problem(input string what);
        $display("%0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic check_word(input string name, input logic [`WB_DAT_WIDTH-1:0] got,
                              input logic [`WB_DAT_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pins(input logic [3:0] led_n_exp, input logic csi_exp,
                              input logic [7:0] p1_exp, input logic [7:0] p2_exp);
        if ({led_n_o, csi_rstn_o, pmod1_o, pmod2_o}
            !== {led_n_exp, csi_exp, p1_exp, p2_exp}) begin
            $write("[FAIL] %0t ns led_n_o/csi_rstn_o/pmod1_o/pmod2_o", $time);
            $display(" got %h/%b/%h/%h expected %h/%b/%h/%h",
                     led_n_o, csi_rstn_o, pmod1_o, pmod2_o,
                     led_n_exp, csi_exp, p1_exp, p2_exp);
            abort_run();
        end
    endtask

    function automatic logic is_uart_reg(input logic [`WB_ADR_WIDTH-1:0] adr,
                                         input cam_ctl_pkg::uart_reg_t r);
        return (adr[`DEC_MSB:`DEC_LSB] == cam_ctl_pkg::TGT_UART) && (adr[1:0] == r);
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b[i] = lfsr_state[0];   // one step per bit
        end
    endtask

    // --------------------
    // bus and serial drivers
    task automatic bus_access(input logic [`WB_ADR_WIDTH-1:0] adr,
                              input logic [`WB_DAT_WIDTH-1:0] dat, input logic we,
                              output logic [`WB_DAT_WIDTH-1:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_sel_i <= '1;
        wb_we_i  <= we;
        wb_stb_i <= 1'b1;
        @(negedge clk);
        while (!wb_ack_o && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack_o) begin
            report_problem($sformatf("no acknowledge for address %h", adr));
        end else if (waited != 0) begin
            report_problem($sformatf("acknowledge for address %h came %0d cycles late",
                                     adr, waited));
        end else begin
            rdata = wb_dat_o;
            @(posedge clk);         // acknowledged edge
            wb_stb_i <= 1'b0;
            wb_we_i  <= 1'b0;
        end
    endtask

    task automatic wait_status(input logic [`WB_DAT_WIDTH-1:0] mask,
                               input logic [`WB_DAT_WIDTH-1:0] value, input string what);
        logic [`WB_DAT_WIDTH-1:0] st;
        int                       polls;
        polls = 0;
        bus_access(UART_STATUS, '0, 1'b0, st);
        while ((st & mask) != value && polls < POLL_LIMIT) begin
            bus_access(UART_STATUS, '0, 1'b0, st);
            polls++;
        end
        if ((st & mask) != value) begin
            report_problem(what);
        end
    endtask

    task automatic write_reg(input logic [`WB_ADR_WIDTH-1:0] adr,
                             input logic [`WB_DAT_WIDTH-1:0] dat);
        logic [`WB_DAT_WIDTH-1:0] unused;
        bus_access(adr, dat, 1'b1, unused);
        if (is_uart_reg(adr, cam_ctl_pkg::REG_DIV)) begin
            div_m = dat[7:0];
        end
        if (adr[`DEC_MSB:`DEC_LSB] == cam_ctl_pkg::TGT_GPIO) begin
            gpio_m[adr[1:0]] = (adr[1:0] == 2'd0) ? {4'h0, dat[3:0]} : dat[7:0];
            @(negedge clk);
            check_pins(~gpio_m[0][3:0], gpio_m[1][0], gpio_m[2], gpio_m[3]);
        end
    endtask

    task automatic receive_byte(input logic [7:0] b);
        int period;
        period = int'(div_m) + 1;
        @(posedge clk);
        uart_rx_i <= 1'b0;          // start bit
        for (int i = 0; i < 8; i++) begin
            repeat (period) @(posedge clk);
            uart_rx_i <= b[i];
        end
        repeat (period) @(posedge clk);
        uart_rx_i <= 1'b1;
        repeat (period) @(posedge clk);
        if (rx_full_m) begin
            wait_status(32'h4, 32'h4, "rx_overrun never set after a second byte");
        end else begin
            wait_status(32'h2, 32'h2, "rx_full never set after a received byte");
        end
        rx_ovr_m  = rx_full_m;
        rx_full_m = 1'b1;
    endtask

    task automatic capture_tx_byte(output logic [7:0] b);
        int period;
        int waited;
        period = int'(div_m) + 1;
        waited = 0;
        @(negedge clk);
        while (uart_tx_o && waited < POLL_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (uart_tx_o) begin
            report_problem("no start bit on uart_tx_o after a data write");
        end else begin
            repeat (period / 2) @(negedge clk);     // middle of start bit
            for (int i = 0; i < 8; i++) begin
                repeat (period) @(negedge clk);
                b[i] = uart_tx_o;
            end
            repeat (period) @(negedge clk);
            if (!uart_tx_o) begin
                report_problem("stop bit on uart_tx_o sampled low");
            end
        end
    endtask

    task automatic transmit_and_check(input logic [7:0] b);
        logic [7:0]               got;
        logic [`WB_DAT_WIDTH-1:0] st;
        bus_access(UART_DATA, {24'h0, b}, 1'b1, st);
        fork
            capture_tx_byte(got);
            begin
                repeat (3 * (int'(div_m) + 1)) @(posedge clk);
                bus_access(UART_STATUS, '0, 1'b0, st);
                check_word("wb_dat_o (status during tx)", st, {29'h0, rx_ovr_m, rx_full_m, 1'b1});
            end
        join
        check_byte("uart_tx_o", got, b);
        wait_status(32'h1, 32'h0, "tx busy never cleared after the stop bit");
    endtask

    task automatic random_traffic(input int count);
        logic [7:0]               b;
        logic [`WB_DAT_WIDTH-1:0] got;
        for (int k = 0; k < count; k++) begin
            random_byte(b);
            receive_byte(b);
            bus_access(UART_DATA, '0, 1'b0, got);
            rx_full_m = 1'b0;
            rx_ovr_m  = 1'b0;
            check_word("wb_dat_o (rx data)", got, {24'h0, b});
            bus_access(UART_STATUS, '0, 1'b0, got);
            check_word("wb_dat_o (status)", got, '0);
            transmit_and_check(b);
        end
    endtask

    // --------------------
    // main sequence
    initial begin
        int                       fd;
        int                       code;
        int                       count;
        int                       waited;
        logic [8*8-1:0]           kind;
        logic [8*128-1:0]         rest;
        logic [`WB_ADR_WIDTH-1:0] adr;
        logic [`WB_DAT_WIDTH-1:0] dat;
        logic [`WB_DAT_WIDTH-1:0] got;
        logic [7:0]               b;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        wb_sel_i   = '0;
        wb_we_i    = 1'b0;
        wb_stb_i   = 1'b0;
        uart_rx_i  = 1'b1;          // idle line
        gpio_m     = '{default: 8'h00};
        div_m      = `UART_DIV_INIT;
        rx_full_m  = 1'b0;
        rx_ovr_m   = 1'b0;
        lfsr_state = 32'h04a4ec54;
        waited     = 0;
        while (reset !== 1'b0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (reset !== 1'b0) begin
            report_problem("reset was never released");
        end
        @(negedge clk);
        check_pins(4'hf, 1'b0, 8'h00, 8'h00);
        fd = $fopen("bench/cam_ctl_patterns.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open bench/cam_ctl_patterns.txt");
        end
        code = $fscanf(fd, "%s", kind);
        while (code == 1) begin
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "wr") begin
                code = $fscanf(fd, "%h %h", adr, dat);
                write_reg(adr, dat);
            end else if (kind == "rd") begin
                code = $fscanf(fd, "%h %h", adr, dat);
                bus_access(adr, '0, 1'b0, got);
                check_word("wb_dat_o", got, dat);
                if (is_uart_reg(adr, cam_ctl_pkg::REG_DATA)) begin
                    rx_full_m = 1'b0;   // data read clears both flags
                    rx_ovr_m  = 1'b0;
                end
            end else if (kind == "txchk") begin
                code = $fscanf(fd, "%h", b);
                transmit_and_check(b);
            end else if (kind == "rxsend") begin
                code = $fscanf(fd, "%h", b);
                receive_byte(b);
            end else if (kind == "rnd") begin
                code = $fscanf(fd, "%d", count);
                random_traffic(count);
            end else begin
                report_problem($sformatf("unknown pattern kind %0s", kind));
            end
            code = $fscanf(fd, "%s", kind);
        end
        $fclose(fd);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- bench/tb_clock.sv
module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;      // 4 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

//--- filelist.f
+incdir+src
src/cam_ctl_pkg.sv
src/wb_decode.sv
src/gpio_regs.sv
src/uart_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/cam_ctl_top.sv
bench/tb_clock.sv
bench/tb_cam_ctl.sv

//--- src/cam_ctl_params.svh
`ifndef CAM_CTL_PARAMS_SVH
`define CAM_CTL_PARAMS_SVH

// --------------------
// bus
// --------------------
`define WB_ADR_WIDTH    16
`define WB_DAT_WIDTH    32
`define WB_SEL_WIDTH    4

// block select field of the address
`define DEC_LSB         6
`define DEC_MSB         9

// --------------------
// uart
// --------------------
`define UART_DIV_WIDTH  8
`define UART_DIV_INIT   53      // 54 clocks per bit
`define SYNC_STAGES     2       // rx input flops

`endif

//--- src/cam_ctl_pkg.sv
`include "cam_ctl_params.svh"

package cam_ctl_pkg;

    // block select, same width as the decode field
    typedef enum logic [`DEC_MSB-`DEC_LSB:0] {
        TGT_UART = 0,
        TGT_GPIO = 1,
        TGT_NONE = 15
    } wb_target_t;

    typedef enum logic [1:0] {
        REG_DATA   = 0,
        REG_STATUS = 1,
        REG_DIV    = 2
    } uart_reg_t;

    typedef enum logic [1:0] {
        GPIO_LED   = 0,
        GPIO_CTL   = 1,     // bit 0 is sensor reset
        GPIO_PMOD1 = 2,
        GPIO_PMOD2 = 3
    } gpio_reg_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

//--- src/cam_ctl_top.sv
`include "cam_ctl_params.svh"

module cam_ctl_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`WB_ADR_WIDTH-1:0]   wb_adr_i,
    input  logic [`WB_DAT_WIDTH-1:0]   wb_dat_i,
    input  logic [`WB_SEL_WIDTH-1:0]   wb_sel_i,
    input  logic                       wb_we_i,
    input  logic                       wb_stb_i,
    output logic [`WB_DAT_WIDTH-1:0]   wb_dat_o,
    output logic                       wb_ack_o,
    input  logic                       uart_rx_i,
    output logic                       uart_tx_o,
    output logic                       csi_rstn_o,
    output logic [3:0]                 led_n_o,
    output logic [7:0]                 pmod1_o,
    output logic [7:0]                 pmod2_o
);

    logic                        gpio_stb;
    logic                        uart_stb;
    logic [`WB_DAT_WIDTH-1:0]    gpio_dat;
    logic [`WB_DAT_WIDTH-1:0]    uart_dat;

    logic                        tx_start;
    logic [7:0]                  tx_data;
    logic                        tx_busy;
    logic                        rx_valid;
    logic [7:0]                  rx_data;
    logic [`UART_DIV_WIDTH-1:0]  divider;     // shared by tx and rx

    wb_decode u_wb_decode (
        .wb_adr_i   (wb_adr_i),
        .wb_stb_i   (wb_stb_i),
        .gpio_dat_i (gpio_dat),
        .uart_dat_i (uart_dat),
        .gpio_stb_o (gpio_stb),
        .uart_stb_o (uart_stb),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o)
    );

    gpio_regs u_gpio_regs (
        .clk        (clk),
        .reset      (reset),
        .stb_i      (gpio_stb),
        .adr_i      (wb_adr_i[1:0]),
        .dat_i      (wb_dat_i),
        .we_i       (wb_we_i),
        .dat_o      (gpio_dat),
        .led_n_o    (led_n_o),
        .csi_rstn_o (csi_rstn_o),
        .pmod1_o    (pmod1_o),
        .pmod2_o    (pmod2_o)
    );

    uart_regs u_uart_regs (
        .clk        (clk),
        .reset      (reset),
        .stb_i      (uart_stb),
        .adr_i      (wb_adr_i[1:0]),
        .dat_i      (wb_dat_i),
        .sel_i      (wb_sel_i),
        .we_i       (wb_we_i),
        .tx_busy_i  (tx_busy),
        .rx_valid_i (rx_valid),
        .rx_data_i  (rx_data),
        .dat_o      (uart_dat),
        .tx_start_o (tx_start),
        .tx_data_o  (tx_data),
        .divider_o  (divider)
    );

    uart_tx u_uart_tx (
        .clk        (clk),
        .reset      (reset),
        .start_i    (tx_start),
        .data_i     (tx_data),
        .divider_i  (divider),
        .busy_o     (tx_busy),
        .tx_o       (uart_tx_o)
    );

    uart_rx u_uart_rx (
        .clk        (clk),
        .reset      (reset),
        .rx_i       (uart_rx_i),
        .divider_i  (divider),
        .valid_o    (rx_valid),
        .data_o     (rx_data)
    );

endmodule

//--- src/gpio_regs.sv
`include "cam_ctl_params.svh"

module gpio_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stb_i,
    input  logic [1:0]                adr_i,
    input  logic [`WB_DAT_WIDTH-1:0]  dat_i,
    input  logic                      we_i,
    output logic [`WB_DAT_WIDTH-1:0]  dat_o,
    output logic [3:0]                led_n_o,
    output logic                      csi_rstn_o,
    output logic [7:0]                pmod1_o,
    output logic [7:0]                pmod2_o
);

    localparam int DW = `WB_DAT_WIDTH;

    cam_ctl_pkg::gpio_reg_t reg_sel;
    logic [3:0]             led_q;
    logic [7:0]             ctl_q;
    logic [7:0]             pmod1_q;
    logic [7:0]             pmod2_q;

    assign reg_sel = cam_ctl_pkg::gpio_reg_t'(adr_i);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            led_q   <= '0;      // leds off
            ctl_q   <= '0;      // sensor held in reset
            pmod1_q <= '0;
            pmod2_q <= '0;
        end else if (stb_i && we_i) begin
            case (reg_sel)
                cam_ctl_pkg::GPIO_LED:   led_q   <= dat_i[3:0];
                cam_ctl_pkg::GPIO_CTL:   ctl_q   <= dat_i[7:0];
                cam_ctl_pkg::GPIO_PMOD1: pmod1_q <= dat_i[7:0];
                cam_ctl_pkg::GPIO_PMOD2: pmod2_q <= dat_i[7:0];
            endcase
        end
    end

    // readback, zero extended
    always_comb begin
        case (reg_sel)
            cam_ctl_pkg::GPIO_LED:   dat_o = DW'(led_q);
            cam_ctl_pkg::GPIO_CTL:   dat_o = DW'(ctl_q);
            cam_ctl_pkg::GPIO_PMOD1: dat_o = DW'(pmod1_q);
            cam_ctl_pkg::GPIO_PMOD2: dat_o = DW'(pmod2_q);
            default:                 dat_o = '0;
        endcase
    end

    assign led_n_o    = ~led_q;     // board leds are active low
    assign csi_rstn_o = ctl_q[0];
    assign pmod1_o    = pmod1_q;
    assign pmod2_o    = pmod2_q;

endmodule

//--- src/uart_regs.sv
`include "cam_ctl_params.svh"

module uart_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stb_i,
    input  logic [1:0]                 adr_i,
    input  logic [`WB_DAT_WIDTH-1:0]   dat_i,
    input  logic [`WB_SEL_WIDTH-1:0]   sel_i,
    input  logic                       we_i,
    input  logic                       tx_busy_i,
    input  logic                       rx_valid_i,
    input  logic [7:0]                 rx_data_i,
    output logic [`WB_DAT_WIDTH-1:0]   dat_o,
    output logic                       tx_start_o,
    output logic [7:0]                 tx_data_o,
    output logic [`UART_DIV_WIDTH-1:0] divider_o
);

    localparam int DW   = `WB_DAT_WIDTH;
    localparam int DIVW = `UART_DIV_WIDTH;

    cam_ctl_pkg::uart_reg_t reg_sel;
    logic                   tx_accept;
    logic                   wr_div;
    logic                   rd_data;
    logic [7:0]             rx_buf_q;
    logic                   rx_full_q;
    logic                   rx_overrun_q;

    assign reg_sel   = cam_ctl_pkg::uart_reg_t'(adr_i);
    // writes while the transmitter is taken are dropped
    assign tx_accept = stb_i && we_i && sel_i[0] && (reg_sel == cam_ctl_pkg::REG_DATA)
                       && !tx_busy_i && !tx_start_o;
    assign wr_div    = stb_i && we_i && sel_i[0] && (reg_sel == cam_ctl_pkg::REG_DIV);
    assign rd_data   = stb_i && !we_i && (reg_sel == cam_ctl_pkg::REG_DATA);

    // --------------------
    // transmit and divider
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_start_o <= 1'b0;
            divider_o  <= DIVW'(`UART_DIV_INIT);
        end else begin
            tx_start_o <= tx_accept;    // one cycle pulse
            if (wr_div) begin
                divider_o <= dat_i[DIVW-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_accept) begin
            tx_data_o <= dat_i[7:0];
        end
        if (rx_valid_i) begin
            rx_buf_q <= rx_data_i;      // newest byte wins
        end
    end

    // --------------------
    // receive flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_full_q    <= 1'b0;
            rx_overrun_q <= 1'b0;
        end else if (rx_valid_i) begin
            rx_full_q    <= 1'b1;
            rx_overrun_q <= !rd_data && (rx_full_q || rx_overrun_q);
        end else if (rd_data) begin
            rx_full_q    <= 1'b0;
            rx_overrun_q <= 1'b0;
        end
    end

    always_comb begin
        case (reg_sel)
            cam_ctl_pkg::REG_DATA:   dat_o = DW'(rx_buf_q);
            cam_ctl_pkg::REG_STATUS: dat_o = DW'({rx_overrun_q, rx_full_q, tx_busy_i});
            cam_ctl_pkg::REG_DIV:    dat_o = DW'(divider_o);
            default:                 dat_o = '0;
        endcase
    end

    // a start pulse always finds the transmitter idle and makes it busy next cycle
    assert property (@(posedge clk) disable iff (reset)
        $rose(tx_start_o) |-> !tx_busy_i ##1 tx_busy_i)
        else $error("uart_regs: tx_start issued while transmitter busy");

endmodule

//--- src/uart_rx.sv
`include "cam_ctl_params.svh"

module uart_rx (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       rx_i,
    input  logic [`UART_DIV_WIDTH-1:0] divider_i,
    output logic                       valid_o,
    output logic [7:0]                 data_o
);

    localparam int SYNC = `SYNC_STAGES;

    cam_ctl_pkg::rx_state_t      state;
    logic [SYNC-1:0]             sync_q;
    logic                        rx_s;
    logic                        rx_prev;
    logic                        fall;
    logic [`UART_DIV_WIDTH-1:0]  timer;
    logic [`UART_DIV_WIDTH-1:0]  half;
    logic [2:0]                  bit_cnt;
    logic [7:0]                  shift_q;
    logic                        bit_end;

    // --------------------
    // input synchronizer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q  <= '1;
            rx_prev <= 1'b1;
        end else begin
            sync_q  <= {sync_q[SYNC-2:0], rx_i};
            rx_prev <= rx_s;
        end
    end

    assign rx_s    = sync_q[SYNC-1];
    assign fall    = rx_prev && !rx_s;
    assign half    = divider_i >> 1;
    assign bit_end = (timer >= divider_i);

    // --------------------
    // frame FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= cam_ctl_pkg::RX_IDLE;
            timer   <= '0;
            bit_cnt <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            timer   <= timer + 1'b1;
            case (state)
                cam_ctl_pkg::RX_IDLE: begin
                    timer <= '0;
                    if (fall) begin
                        state <= cam_ctl_pkg::RX_START;
                    end
                end
                cam_ctl_pkg::RX_START: begin
                    if (timer >= half) begin    // middle of start bit
                        timer   <= '0;
                        bit_cnt <= '0;
                        state   <= rx_s ? cam_ctl_pkg::RX_IDLE : cam_ctl_pkg::RX_DATA;
                    end
                end
                cam_ctl_pkg::RX_DATA: begin
                    if (bit_end) begin
                        timer   <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= cam_ctl_pkg::RX_STOP;
                        end
                    end
                end
                cam_ctl_pkg::RX_STOP: begin
                    if (bit_end) begin
                        valid_o <= rx_s;    // framing error drops the byte
                        state   <= cam_ctl_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cam_ctl_pkg::RX_DATA && bit_end) begin
            shift_q <= {rx_s, shift_q[7:1]};    // lsb arrives first
        end
    end

    assign data_o = shift_q;

endmodule

//--- src/uart_tx.sv
`include "cam_ctl_params.svh"

module uart_tx (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start_i,
    input  logic [7:0]                 data_i,
    input  logic [`UART_DIV_WIDTH-1:0] divider_i,
    output logic                       busy_o,
    output logic                       tx_o
);

    cam_ctl_pkg::tx_state_t      state;
    logic [`UART_DIV_WIDTH-1:0]  timer;
    logic [2:0]                  bit_cnt;
    logic [7:0]                  shift_q;
    logic                        bit_end;

    assign bit_end = (timer >= divider_i);      // divider + 1 clocks per bit
    assign busy_o  = (state != cam_ctl_pkg::TX_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= cam_ctl_pkg::TX_IDLE;
            timer   <= '0;
            bit_cnt <= '0;
            tx_o    <= 1'b1;    // line idles high
        end else begin
            timer <= (bit_end || !busy_o) ? '0 : timer + 1'b1;
            case (state)
                cam_ctl_pkg::TX_IDLE: begin
                    if (start_i) begin
                        state <= cam_ctl_pkg::TX_START;
                        tx_o  <= 1'b0;
                    end
                end
                cam_ctl_pkg::TX_START: begin
                    if (bit_end) begin
                        state   <= cam_ctl_pkg::TX_DATA;
                        bit_cnt <= '0;
                        tx_o    <= shift_q[0];  // lsb first
                    end
                end
                cam_ctl_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            state <= cam_ctl_pkg::TX_STOP;
                            tx_o  <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx_o    <= shift_q[1];
                        end
                    end
                end
                cam_ctl_pkg::TX_STOP: begin
                    if (bit_end) begin
                        state <= cam_ctl_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_o && start_i) begin
            shift_q <= data_i;
        end else if (state == cam_ctl_pkg::TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (state == cam_ctl_pkg::TX_IDLE) |-> tx_o)
        else $error("uart_tx: line low while idle");

endmodule

//--- src/wb_decode.sv
`include "cam_ctl_params.svh"

module wb_decode (
    input  logic [`WB_ADR_WIDTH-1:0]  wb_adr_i,
    input  logic                      wb_stb_i,
    input  logic [`WB_DAT_WIDTH-1:0]  gpio_dat_i,
    input  logic [`WB_DAT_WIDTH-1:0]  uart_dat_i,
    output logic                      gpio_stb_o,
    output logic                      uart_stb_o,
    output logic [`WB_DAT_WIDTH-1:0]  wb_dat_o,
    output logic                      wb_ack_o
);

    cam_ctl_pkg::wb_target_t target;

    always_comb begin
        case (wb_adr_i[`DEC_MSB:`DEC_LSB])
            cam_ctl_pkg::TGT_UART: target = cam_ctl_pkg::TGT_UART;
            cam_ctl_pkg::TGT_GPIO: target = cam_ctl_pkg::TGT_GPIO;
            default:               target = cam_ctl_pkg::TGT_NONE;
        endcase
    end

    assign uart_stb_o = wb_stb_i && (target == cam_ctl_pkg::TGT_UART);
    assign gpio_stb_o = wb_stb_i && (target == cam_ctl_pkg::TGT_GPIO);

    // no wait states, every target answers in the strobe cycle
    always_comb begin
        wb_dat_o = '0;
        wb_ack_o = 1'b0;
        if (wb_stb_i) begin
            case (target)
                cam_ctl_pkg::TGT_UART: begin
                    wb_dat_o = uart_dat_i;
                    wb_ack_o = 1'b1;
                end
                cam_ctl_pkg::TGT_GPIO: begin
                    wb_dat_o = gpio_dat_i;
                    wb_ack_o = 1'b1;
                end
                default: begin
                    wb_ack_o = 1'b1;    // unmapped, reads zero
                end
            endcase
        end
    end

endmodule
